// ==== lfbuf_pkg.sv ====
// Shared widths, types and constants of the line-buffer render controller.
// A color whose low nibble is zero is transparent; lines are LINE_PIXELS wide.
`default_nettype none

package lfbuf_pkg;

    localparam int HDUMP_W     = 9;                  // Bit 8 is the end-of-line carry.
    localparam int VDUMP_W     = 8;
    localparam int LEN_W       = 6;
    localparam int PAL_W       = 8;
    localparam int LINE_PIXELS = 256;                // Pixels drawn per line.
    localparam int CEN_DIV     = 3;                  // Minimum clocks between cen pulses.
    localparam int CEN_W       = $clog2(CEN_DIV);    // Width of the cen divider.

    typedef logic [HDUMP_W-1:0] hdump_t;
    typedef logic [VDUMP_W-1:0] vdump_t;
    typedef logic [LEN_W-1:0]   len_t;               // Region length in cen ticks minus one.
    typedef logic [PAL_W-1:0]   pal_t;

    localparam vdump_t BLANK_LINE = 8'h17;           // Line with no pixels at all.

    typedef struct packed {
        len_t hbs_len;                               // Blank start to sync.
        len_t hsy_len;                               // Sync width.
        len_t hsa_len;                               // Sync end to active video.
    } hblank_cfg_t;

    typedef struct packed {
        hdump_t hdump;
        vdump_t vdump;
    } pix_pos_t;

    typedef struct packed {
        pal_t fix;
        pal_t scroll;
        pal_t obj;
    } layer_pix_t;

    typedef enum logic [1:0] {
        HB_IDLE,
        HB_START,
        HB_SYNC,
        HB_ACTIVE_WAIT
    } hb_state_t;

endpackage

`default_nettype wire

// ==== lfbuf_hblank_seq.sv ====
// Horizontal blanking sequencer; a new ln_hs edge restarts the sequence at once.
// Region lengths are sampled from cfg when each region is entered.
`default_nettype none

module lfbuf_hblank_seq import lfbuf_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        ln_hs,
    input  logic        cen,
    input  hblank_cfg_t cfg,
    output logic        line_start,
    output logic        blanking,
    output logic        hs,
    output logic        lhbl
);

    logic      hs_l;                                  // Delayed ln_hs for edge detection.
    logic      hs_edge;
    len_t      cnt;                                   // Down-counter of the current region.
    hb_state_t state;

    assign hs_edge  = ln_hs & ~hs_l;                  // Rising edge of the line sync.
    assign blanking = state != HB_IDLE;               // Any region still running.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hs_l       <= 1'b0;
            line_start <= 1'b0;
            hs         <= 1'b0;
            lhbl       <= 1'b0;
            cnt        <= '0;
            state      <= HB_IDLE;
        end else begin
            hs_l       <= ln_hs;
            line_start <= hs_edge;                    // One clock after the edge.
            if (hs_edge) begin
                state <= HB_START;                    // Blank start region begins.
                cnt   <= cfg.hbs_len;
                hs    <= 1'b0;
                lhbl  <= 1'b0;                        // Video is blanked again.
            end else if (cen && blanking) begin
                if (cnt != '0) begin
                    cnt <= len_t'(cnt - 1'b1);        // Region still running.
                end else begin
                    case (state)
                        HB_START: begin
                            state <= HB_SYNC;
                            cnt   <= cfg.hsy_len;
                            hs    <= 1'b1;            // Sync pulse starts.
                        end
                        HB_SYNC: begin
                            state <= HB_ACTIVE_WAIT;
                            cnt   <= cfg.hsa_len;
                            hs    <= 1'b0;
                        end
                        default: begin
                            state <= HB_IDLE;         // Back porch done.
                            lhbl  <= 1'b1;            // Active video may start.
                        end
                    endcase
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== lfbuf_pixel_clock.sv ====
// Pixel strobe and horizontal counter; cen is free running only while blanking.
// In the active span each cen waits for fetch_ok, so the pixel rate follows the source.
`default_nettype none

module lfbuf_pixel_clock import lfbuf_pkg::*; (
    input  logic   clk,
    input  logic   arst_n,
    input  logic   line_start,
    input  logic   blanking,
    input  logic   fetch_ok,
    input  vdump_t vdump,
    output logic   cen,
    output hdump_t hdump,
    output logic   active,
    output logic   line_end
);

    logic [CEN_W-1:0] div_cnt;                        // Clocks since the last cen.
    logic             div_max;
    logic             run;
    logic             blank_l;                        // Delayed blanking for its falling edge.
    logic             draw;                           // This line has pixels to draw.
    hdump_t           hdump_nx;

    assign div_max  = div_cnt == CEN_W'(CEN_DIV - 1);
    assign run      = blanking | (active & fetch_ok); // Stall while a fetch is pending.
    assign hdump_nx = hdump_t'(hdump + 1'b1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt  <= '0;
            cen      <= 1'b0;
            hdump    <= '0;
            active   <= 1'b0;
            line_end <= 1'b0;
            blank_l  <= 1'b0;
            draw     <= 1'b0;
        end else begin
            blank_l  <= blanking;
            cen      <= div_max & run;
            line_end <= 1'b0;                         // Single-cycle pulse.
            if (div_max && run) begin
                div_cnt <= '0;                        // Strobe issued, start a new period.
            end else if (!div_max) begin
                div_cnt <= CEN_W'(div_cnt + 1'b1);    // Saturates at the division limit.
            end
            if (line_start) begin
                hdump    <= '0;
                active   <= 1'b0;                     // Abandon any unfinished line.
                draw     <= vdump != BLANK_LINE;
                line_end <= vdump == BLANK_LINE;      // Blank line is done at once.
            end else if (blank_l && !blanking && draw) begin
                active <= 1'b1;                       // Blanking over, pixels start.
                draw   <= 1'b0;
            end else if (active && cen) begin
                hdump <= hdump_nx;                    // Pixel strobed, move to the next.
                if (hdump_nx == hdump_t'(LINE_PIXELS)) begin
                    active   <= 1'b0;                 // Carry into bit 8 ends the line.
                    line_end <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== lfbuf_layer_fetch.sv ====
// Four-phase req/ack fetch of the three layer colors for the current pixel.
// A new request waits until the source has dropped pix_ack.
`default_nettype none

module lfbuf_layer_fetch import lfbuf_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       active,
    input  hdump_t     hdump,
    input  vdump_t     vdump,
    input  logic       cen,
    output logic       pix_req,
    output pix_pos_t   pix_pos,
    input  logic       pix_ack,
    input  layer_pix_t pix_data,
    output logic       fetch_ok,
    output layer_pix_t pix
);

    logic   act_l;                                    // Delayed active.
    hdump_t hdump_l;                                  // Delayed hdump.
    logic   pend;                                     // Pixel waiting for its request.
    logic   new_pix;
    logic   start;
    logic   done;

    // A pixel becomes current when the span opens or hdump moves on.
    assign new_pix = active & (~act_l | (hdump != hdump_l));
    // The previous handshake must be fully closed before a new request.
    assign start   = active & (pend | new_pix) & ~pix_req & ~pix_ack;
    assign done    = pix_req & pix_ack;               // Source has returned the colors.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            act_l    <= 1'b0;
            hdump_l  <= '0;
            pend     <= 1'b0;
            pix_req  <= 1'b0;
            fetch_ok <= 1'b0;
        end else begin
            act_l   <= active;
            hdump_l <= hdump;
            pend    <= active & (pend | new_pix) & ~start;
            if (start) begin
                pix_req <= 1'b1;                      // Phase one, request with stable pos.
            end else if (done) begin
                pix_req <= 1'b0;                      // Phase three, release the request.
            end
            if (done) begin
                fetch_ok <= active;                   // Stale data from an aborted line is ignored.
            end else if (cen || !active) begin
                fetch_ok <= 1'b0;                     // Colors consumed by the strobe.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            pix_pos <= '{hdump: hdump, vdump: vdump};
        end
        if (done) begin
            pix <= pix_data;                          // Held until the next fetch completes.
        end
    end

endmodule

`default_nettype wire

// ==== lfbuf_line_writer.sv ====
// Priority mixer and line buffer write port; one write per active cen.
// With hflip set the line is written from address 255 down to 0.
`default_nettype none

module lfbuf_line_writer import lfbuf_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       cen,
    input  logic       active,
    input  logic       line_start,
    input  logic       line_end,
    input  hdump_t     hdump,
    input  logic       hflip,
    input  layer_pix_t pix,
    output logic       ln_we,
    output hdump_t     ln_addr,
    output pal_t       ln_data,
    output logic       ln_done
);

    pal_t   mix;                                      // Color picked by priority.
    hdump_t addr;

    always_comb begin
        if (pix.obj[3:0] != 4'd0) begin
            mix = pix.obj;                            // Objects sit on top.
        end else if (pix.fix[3:0] != 4'd0) begin
            mix = pix.fix;
        end else begin
            mix = pix.scroll;                         // Scroll is the backdrop.
        end
    end

    // Mirroring only flips the pixel index; bit 8 is always zero here.
    assign addr = hflip ? {1'b0, ~hdump[7:0]} : hdump_t'(hdump[7:0]);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ln_we   <= 1'b0;
            ln_done <= 1'b0;
        end else begin
            ln_we <= cen & active;                    // Write the pixel just strobed.
            if (line_start) begin
                ln_done <= 1'b0;
            end else if (line_end) begin
                ln_done <= 1'b1;                      // Held until the next line.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cen && active) begin
            ln_addr <= addr;
            ln_data <= mix;
        end
    end

endmodule

`default_nettype wire

// ==== lfbuf_top.sv ====
// Line-buffer render controller top; the line buffer and the pixel source sit outside.
`default_nettype none

module lfbuf_top import lfbuf_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        ln_hs,
    input  vdump_t      ln_v,
    input  logic        hflip,
    input  hblank_cfg_t cfg,
    output logic        pix_req,
    output pix_pos_t    pix_pos,
    input  logic        pix_ack,
    input  layer_pix_t  pix_data,
    output logic        ln_we,
    output hdump_t      ln_addr,
    output pal_t        ln_data,
    output logic        ln_done,
    output logic        cen,
    output logic        hs,
    output logic        lhbl,
    output hdump_t      hdump
);

    logic       line_start;
    logic       blanking;
    logic       active;
    logic       line_end;
    logic       fetch_ok;
    layer_pix_t pix;                                  // Colors of the current pixel.

    lfbuf_hblank_seq u_hblank_seq (
        .clk        (clk),
        .arst_n     (arst_n),
        .ln_hs      (ln_hs),
        .cen        (cen),
        .cfg        (cfg),
        .line_start (line_start),
        .blanking   (blanking),
        .hs         (hs),
        .lhbl       (lhbl)
    );

    lfbuf_pixel_clock u_pixel_clock (
        .clk        (clk),
        .arst_n     (arst_n),
        .line_start (line_start),
        .blanking   (blanking),
        .fetch_ok   (fetch_ok),
        .vdump      (ln_v),
        .cen        (cen),
        .hdump      (hdump),
        .active     (active),
        .line_end   (line_end)
    );

    lfbuf_layer_fetch u_layer_fetch (
        .clk        (clk),
        .arst_n     (arst_n),
        .active     (active),
        .hdump      (hdump),
        .vdump      (ln_v),
        .cen        (cen),
        .pix_req    (pix_req),
        .pix_pos    (pix_pos),
        .pix_ack    (pix_ack),
        .pix_data   (pix_data),
        .fetch_ok   (fetch_ok),
        .pix        (pix)
    );

    lfbuf_line_writer u_line_writer (
        .clk        (clk),
        .arst_n     (arst_n),
        .cen        (cen),
        .active     (active),
        .line_start (line_start),
        .line_end   (line_end),
        .hdump      (hdump),
        .hflip      (hflip),
        .pix        (pix),
        .ln_we      (ln_we),
        .ln_addr    (ln_addr),
        .ln_data    (ln_data),
        .ln_done    (ln_done)
    );

endmodule

`default_nettype wire

// ==== tb_lfbuf_assert.sv ====
// Handshake and write-window assertions bound into the DUT top level.
// Only top-level ports are watched, and nothing is checked while reset is held.
`default_nettype none

module tb_lfbuf_assert import lfbuf_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     pix_req,
    input  pix_pos_t pix_pos,
    input  logic     pix_ack,
    input  logic     ln_we,
    input  logic     lhbl
);

    int fail_cnt = 0;                                 // Number of failed assertions.

    // The position must not move while a request is held.
    pos_stable: assert property (@(posedge clk) disable iff (!arst_n)
        pix_req && $past(pix_req) |-> $stable(pix_pos))
        else begin
            $error("pix_pos changed while pix_req was high");
            fail_cnt++;
        end

    // A new request only follows a fully closed handshake.
    req_after_ack: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(pix_req) |-> !$past(pix_ack))
        else begin
            $error("pix_req rose while pix_ack was still high");
            fail_cnt++;
        end

    we_in_active: assert property (@(posedge clk) disable iff (!arst_n)
        ln_we |-> lhbl)
        else begin
            $error("ln_we pulsed while lhbl was low");
            fail_cnt++;
        end

endmodule

bind lfbuf_top tb_lfbuf_assert u_assert (
    .clk     (clk),
    .arst_n  (arst_n),
    .pix_req (pix_req),
    .pix_pos (pix_pos),
    .pix_ack (pix_ack),
    .ln_we   (ln_we),
    .lhbl    (lhbl)
);

`default_nettype wire

// ==== tb_lfbuf_checker.sv ====
// Reference model of the line controller built only from its port activity.
// Assumes cfg, ln_v and hflip stay still from the ln_hs edge until the line is done.
`default_nettype none

module tb_lfbuf_checker import lfbuf_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        ln_hs,
    input  vdump_t      ln_v,
    input  logic        hflip,
    input  hblank_cfg_t cfg,
    input  logic        pix_req,
    input  pix_pos_t    pix_pos,
    input  logic        pix_ack,
    input  layer_pix_t  pix_data,
    input  logic        ln_we,
    input  hdump_t      ln_addr,
    input  pal_t        ln_data,
    input  logic        ln_done,
    input  logic        cen,
    input  logic        hs,
    input  logic        lhbl,
    input  hdump_t      hdump,
    output int          value_errs,
    output int          rule_errs
);

    layer_pix_t  colors [LINE_PIXELS];                // Colors handed out per pixel.
    hblank_cfg_t line_cfg;                            // Settings captured at the line start.
    vdump_t      line_v;
    logic        line_flip;
    logic        line_blank;
    logic        line_open;
    logic        done_seen;
    logic        wait_lhbl;                           // Sync is over and the back porch runs.
    logic        ln_hs_q;
    logic        hs_q;
    logic        lhbl_q;
    logic        done_q;
    int          hs_cnt;
    int          post_cnt;
    int          wr_cnt;
    int          fetch_cnt;
    int          cen_gap;
    int          exp_addr;
    int          exp_cnt;

    // Object first, then fix, and scroll when both are transparent.
    function automatic pal_t pick_color(input layer_pix_t p);
        if (p.obj[3:0] != 4'h0) begin
            return p.obj;
        end
        if (p.fix[3:0] != 4'h0) begin
            return p.fix;
        end
        return p.scroll;
    endfunction

    task automatic value_error(input string name, input int got, input int exp);
        $display("ERROR t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        value_errs++;
    endtask

    task automatic rule_error(input string what);
        $display("ERROR t=%0t %s", $time, what);
        rule_errs++;
    endtask

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            value_errs = 0;
            rule_errs  = 0;
            line_cfg   = '0;
            line_v     = '0;
            line_flip  = 1'b0;
            line_blank = 1'b0;
            line_open  = 1'b0;
            done_seen  = 1'b0;
            wait_lhbl  = 1'b0;
            ln_hs_q    = 1'b0;
            hs_q       = 1'b0;
            lhbl_q     = 1'b0;
            done_q     = 1'b0;
            hs_cnt     = 0;
            post_cnt   = 0;
            wr_cnt     = 0;
            fetch_cnt  = 0;
            cen_gap    = CEN_DIV;
        end else begin
            if (ln_hs && !ln_hs_q) begin              // The DUT sees the same edge here.
                if (line_open && !done_seen) begin
                    rule_error("previous line never raised ln_done");
                end
                line_open  = 1'b1;
                done_seen  = 1'b0;
                line_cfg   = cfg;
                line_v     = ln_v;
                line_flip  = hflip;
                line_blank = ln_v == BLANK_LINE;
                wr_cnt     = 0;
                fetch_cnt  = 0;
                hs_cnt     = 0;
                wait_lhbl  = 1'b0;
            end
            cen_gap++;
            if (cen) begin
                if (cen_gap < CEN_DIV) begin
                    rule_error("two cen pulses came closer than CEN_DIV clocks");
                end
                cen_gap = 0;
            end
            if (cen && hs) begin
                hs_cnt++;                             // Strobes seen inside the sync pulse.
            end
            if (hs_q && !hs) begin
                if (hs_cnt != int'(line_cfg.hsy_len) + 1) begin
                    value_error("hs width in cen pulses", hs_cnt, int'(line_cfg.hsy_len) + 1);
                end
                hs_cnt    = 0;
                post_cnt  = 0;
                wait_lhbl = 1'b1;
            end
            if (cen && wait_lhbl && !hs && !lhbl) begin
                post_cnt++;
            end
            if (lhbl && !lhbl_q && wait_lhbl) begin
                if (post_cnt != int'(line_cfg.hsa_len) + 1) begin
                    value_error("lhbl delay in cen pulses", post_cnt,
                                int'(line_cfg.hsa_len) + 1);
                end
                if (!done_seen && ln_done) begin
                    rule_error("ln_done was still high when the drawn line began");
                end
                wait_lhbl = 1'b0;
            end
            if (pix_req && pix_ack) begin             // Handshake closes on this edge.
                if (line_blank) begin
                    rule_error("a pixel was fetched on the blank line");
                end
                if (int'(pix_pos.hdump) != fetch_cnt) begin
                    value_error("pix_pos.hdump", pix_pos.hdump, fetch_cnt);
                end
                if (pix_pos.vdump != line_v) begin
                    value_error("pix_pos.vdump", pix_pos.vdump, line_v);
                end
                colors[pix_pos.hdump[7:0]] = pix_data;
                fetch_cnt++;
            end
            if (ln_we) begin
                if (line_blank || wr_cnt >= LINE_PIXELS) begin
                    rule_error("unexpected line buffer write");
                end else if (wr_cnt >= fetch_cnt) begin
                    rule_error("a pixel was written before it was fetched");
                end else begin
                    exp_addr = line_flip ? LINE_PIXELS - 1 - wr_cnt : wr_cnt;
                    if (int'(ln_addr) != exp_addr) begin
                        value_error("ln_addr", ln_addr, exp_addr);
                    end
                    if (ln_data != pick_color(colors[wr_cnt])) begin
                        value_error("ln_data", ln_data, pick_color(colors[wr_cnt]));
                    end
                    if (int'(hdump) != wr_cnt + 1) begin
                        value_error("hdump", hdump, wr_cnt + 1); // Advanced past the write.
                    end
                end
                if (ln_done) begin
                    rule_error("ln_done was high before the last write");
                end
                wr_cnt++;
            end
            if (ln_done && !done_q) begin
                exp_cnt = line_blank ? 0 : LINE_PIXELS;
                if (!line_open) begin
                    rule_error("ln_done rose outside a line");
                end
                if (wr_cnt != exp_cnt) begin
                    value_error("write count", wr_cnt, exp_cnt);
                end
                if (fetch_cnt != exp_cnt) begin
                    value_error("fetch count", fetch_cnt, exp_cnt);
                end
                if (int'(hdump) != exp_cnt) begin
                    value_error("hdump at ln_done", hdump, exp_cnt);
                end
                done_seen = 1'b1;
            end
            if (done_seen && !ln_done) begin
                rule_error("ln_done dropped before the next line started");
                done_seen = 1'b0;
                line_open = 1'b0;
            end
            ln_hs_q = ln_hs;
            hs_q    = hs;
            lhbl_q  = lhbl;
            done_q  = ln_done;
        end
    end

endmodule

`default_nettype wire

// ==== tb_lfbuf.sv ====
// Testbench of the line controller; random lines, settings and source latency from one seed.
// Every fourth line starting at line 2 is the blank line.
`default_nettype none

module tb_lfbuf import lfbuf_pkg::*; ();

    localparam int NUM_LINES = 10;
    localparam int DRV       = 2;                     // Input delay after the rising edge.
    localparam int LIMIT     = 10000;                 // Clocks allowed for any single wait.

    typedef enum logic [1:0] {
        RSP_IDLE,
        RSP_WAIT,
        RSP_ACK
    } rsp_state_t;

    logic        clk;
    logic        arst_n;
    logic        ln_hs;
    vdump_t      ln_v;
    logic        hflip;
    hblank_cfg_t cfg;
    logic        pix_req;
    pix_pos_t    pix_pos;
    logic        pix_ack;
    layer_pix_t  pix_data;
    logic        ln_we;
    hdump_t      ln_addr;
    pal_t        ln_data;
    logic        ln_done;
    logic        cen;
    logic        hs;
    logic        lhbl;
    hdump_t      hdump;
    integer      seed;
    int          value_errs;
    int          rule_errs;
    int          timeouts;
    int          rsp_delay;                           // Clocks left before the ack.
    rsp_state_t  rsp_state;
    bit          ok;

    always #20 clk = ~clk;

    lfbuf_top DUT (
        .clk      (clk),
        .arst_n   (arst_n),
        .ln_hs    (ln_hs),
        .ln_v     (ln_v),
        .hflip    (hflip),
        .cfg      (cfg),
        .pix_req  (pix_req),
        .pix_pos  (pix_pos),
        .pix_ack  (pix_ack),
        .pix_data (pix_data),
        .ln_we    (ln_we),
        .ln_addr  (ln_addr),
        .ln_data  (ln_data),
        .ln_done  (ln_done),
        .cen      (cen),
        .hs       (hs),
        .lhbl     (lhbl),
        .hdump    (hdump)
    );

    tb_lfbuf_checker u_checker (
        .clk        (clk),
        .arst_n     (arst_n),
        .ln_hs      (ln_hs),
        .ln_v       (ln_v),
        .hflip      (hflip),
        .cfg        (cfg),
        .pix_req    (pix_req),
        .pix_pos    (pix_pos),
        .pix_ack    (pix_ack),
        .pix_data   (pix_data),
        .ln_we      (ln_we),
        .ln_addr    (ln_addr),
        .ln_data    (ln_data),
        .ln_done    (ln_done),
        .cen        (cen),
        .hs         (hs),
        .lhbl       (lhbl),
        .hdump      (hdump),
        .value_errs (value_errs),
        .rule_errs  (rule_errs)
    );

    // About half of the colors come out transparent, so all priority cases occur.
    function automatic pal_t random_color();
        pal_t c;
        c = pal_t'($random(seed));
        if ($random(seed) & 1) begin
            c[3:0] = 4'h0;
        end
        return c;
    endfunction

    // The pixel source answers as a four-phase slave after a random latency of 0 to 5 clocks.
    always @(posedge clk) begin
        #DRV;
        case (rsp_state)
            RSP_IDLE: begin
                if (pix_req && !pix_ack) begin
                    rsp_delay = $unsigned($random(seed)) % 6;
                    rsp_state = RSP_WAIT;
                end
            end
            RSP_WAIT: begin
                if (rsp_delay == 0) begin
                    pix_data.fix    = random_color();
                    pix_data.scroll = random_color();
                    pix_data.obj    = random_color();
                    pix_ack         = 1'b1;           // Colors valid with the ack.
                    rsp_state       = RSP_ACK;
                end else begin
                    rsp_delay--;
                end
            end
            RSP_ACK: begin
                if (!pix_req) begin
                    pix_ack   = 1'b0;                 // Last phase of the handshake.
                    rsp_state = RSP_IDLE;
                end
            end
            default: rsp_state = RSP_IDLE;
        endcase
    end

    task automatic wait_blank_start(output bit done);
        int n;
        n = 0;
        while (lhbl !== 1'b0 && n < LIMIT) begin
            @(posedge clk);
            #DRV;
            n++;
        end
        done = lhbl === 1'b0;
    endtask

    // A line is over once its blanking has ended and ln_done is up.
    task automatic wait_line_done(output bit done);
        int n;
        n = 0;
        while (!(ln_done === 1'b1 && lhbl === 1'b1) && n < LIMIT) begin
            @(posedge clk);
            #DRV;
            n++;
        end
        done = ln_done === 1'b1 && lhbl === 1'b1;
    endtask

    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        ln_hs     = 1'b0;
        ln_v      = '0;
        hflip     = 1'b0;
        cfg       = '0;
        pix_ack   = 1'b0;
        pix_data  = '0;
        rsp_state = RSP_IDLE;
        seed      = 22109;
        timeouts  = 0;
        repeat (8) @(posedge clk);
        #DRV;
        arst_n = 1'b1;
        for (int ln_idx = 0; ln_idx < NUM_LINES && timeouts == 0; ln_idx++) begin
            repeat (4) @(posedge clk);
            #DRV;
            cfg.hbs_len = len_t'($random(seed) & 7);  // Short regions keep the run brief.
            cfg.hsy_len = len_t'($random(seed) & 7);
            cfg.hsa_len = len_t'($random(seed) & 7);
            hflip       = $random(seed) & 1;
            ln_v        = (ln_idx % 4 == 2) ? BLANK_LINE : vdump_t'($random(seed));
            @(posedge clk);
            #DRV;
            ln_hs = 1'b1;
            repeat (2) @(posedge clk);
            #DRV;
            wait_blank_start(ok);
            ln_hs = 1'b0;
            if (!ok) begin
                $display("Timeout: lhbl did not drop after ln_hs on line %0d", ln_idx);
                timeouts++;
            end else begin
                wait_line_done(ok);
                if (!ok) begin
                    $display("Timeout: line %0d never finished", ln_idx);
                    timeouts++;
                end
            end
        end
        repeat (4) @(posedge clk);
        $display("Errors: %0d value, %0d rule, %0d assertion, %0d timeout",
                 value_errs, rule_errs, DUT.u_assert.fail_cnt, timeouts);
        if (value_errs == 0 && rule_errs == 0 && DUT.u_assert.fail_cnt == 0 && timeouts == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
lfbuf_pkg.sv
lfbuf_hblank_seq.sv
lfbuf_pixel_clock.sv
lfbuf_layer_fetch.sv
lfbuf_line_writer.sv
lfbuf_top.sv
tb_lfbuf_assert.sv
tb_lfbuf_checker.sv
tb_lfbuf.sv

// ==== Bender.yml ====
package:
  name: lfbuf

sources:
  - lfbuf_pkg.sv
  - lfbuf_hblank_seq.sv
  - lfbuf_pixel_clock.sv
  - lfbuf_layer_fetch.sv
  - lfbuf_line_writer.sv
  - lfbuf_top.sv
  - target: simulation
    files:
      - tb_lfbuf_assert.sv
      - tb_lfbuf_checker.sv
      - tb_lfbuf.sv
